// File: hw/arb_params.svh
//////////////////////////////////////////////////////////////////////
// Arbiter configuration macros
// Requester count, mode select width and generator reset state
//////////////////////////////////////////////////////////////////////

`ifndef ARB_PARAMS_SVH
`define ARB_PARAMS_SVH

// Fixed by the arbitration logic, not a tuning knob
`define ARB_NREQ    4

`define ARB_MODE_W  3       // Mode select width

// Stage order is {s3, s2, s1}
`define ARB_PN_INIT 3'b001  // Only stage 1 set after reset

`endif

// File: hw/arb_pkg.sv
//////////////////////////////////////////////////////////////////////
// Arbiter shared types
// Mode codes and the head-first priority pick
//////////////////////////////////////////////////////////////////////

`include "arb_params.svh"

package arb_pkg;

  // Codes 6 and 7 are left unused and give no grant
  typedef enum logic [`ARB_MODE_W-1:0] {
    MODE_P0   = 3'd0,  // Requester 0 first
    MODE_P1   = 3'd1,
    MODE_P2   = 3'd2,
    MODE_P3   = 3'd3,
    MODE_RR   = 3'd4,  // Round robin
    MODE_RAND = 3'd5   // Pseudo-random head
  } arb_mode_e;

  // Head wins if requesting, otherwise lowest index wins
  function automatic logic [`ARB_NREQ-1:0] pick_from_head(
    input logic [`ARB_NREQ-1:0] req,
    input logic [1:0]           head
  );
    logic [`ARB_NREQ-1:0] pick;
    pick = '0;
    if (req[head]) begin
      pick[head] = 1'b1;
    end else begin
      for (int i = 0; i < `ARB_NREQ; i++) begin
        if (req[i] && (pick == '0)) pick[i] = 1'b1;
      end
    end
    return pick;
  endfunction

endpackage

// File: hw/pn_seq_gen.sv
//////////////////////////////////////////////////////////////////////
// Pseudo-noise sequence generator
// Three-stage LFSR, free running, 2-bit output with period 7
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "arb_params.svh"

module pn_seq_gen (
  input  logic       clk,
  input  logic       rst_n,
  output logic [1:0] rand_val
);

  logic [2:0] pn_q;    // {s3, s2, s1}
  logic       fb;

  // Feedback into stage 1
  assign fb = pn_q[0] ^ pn_q[2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pn_q <= `ARB_PN_INIT;
    end else begin
      pn_q <= {pn_q[1], pn_q[0], fb};  // Shift s1 -> s2 -> s3
    end
  end

  // Output pair is {s3, s2}
  // Runs 0, 1, 3, 3, 2, 1, 2 from reset
  assign rand_val = pn_q[2:1];

endmodule

// File: hw/static_grant.sv
//////////////////////////////////////////////////////////////////////
// Static grant candidates
// Fixed priority for each head requester plus round robin
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "arb_params.svh"

module static_grant
  import arb_pkg::*;
(
  input  logic [`ARB_NREQ-1:0] req,
  input  logic [1:0]           rr_ptr,
  output logic [`ARB_NREQ-1:0] cand_p0,
  output logic [`ARB_NREQ-1:0] cand_p1,
  output logic [`ARB_NREQ-1:0] cand_p2,
  output logic [`ARB_NREQ-1:0] cand_p3,
  output logic [`ARB_NREQ-1:0] cand_rr
);

  // Fixed priority, one candidate per head
  assign cand_p0 = pick_from_head(req, 2'd0);
  assign cand_p1 = pick_from_head(req, 2'd1);
  assign cand_p2 = pick_from_head(req, 2'd2);
  assign cand_p3 = pick_from_head(req, 2'd3);

  // Round robin search
  // Starts one past the last winner and wraps around.
  // The last winner itself is only tried at the end, so it can
  // keep the grant when nobody else is asking.
  always_comb begin
    logic [1:0] idx;
    logic       found;
    cand_rr = '0;
    found   = 1'b0;
    for (int k = 1; k <= `ARB_NREQ; k++) begin
      idx = rr_ptr + k[1:0];  // 2-bit add wraps mod 4
      if (!found && req[idx]) begin
        cand_rr[idx] = 1'b1;
        found        = 1'b1;
      end
    end
  end

endmodule

// File: hw/random_grant.sv
//////////////////////////////////////////////////////////////////////
// Random grant candidate
// Priority pick whose head rotates with the PN generator
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "arb_params.svh"

module random_grant
  import arb_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [`ARB_NREQ-1:0] req,
  output logic [`ARB_NREQ-1:0] cand_rand
);

  logic [1:0] rand_val;  // Current head requester

  // Free running, ignores mode and requests
  pn_seq_gen pn_seq_gen_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .rand_val (rand_val)
  );

  // Head from the generator, rest in ascending order
  assign cand_rand = pick_from_head(req, rand_val);

endmodule

// File: hw/grant_select.sv
//////////////////////////////////////////////////////////////////////
// Grant selector
// Picks the candidate named by the mode and registers it as the
// grant, also returns the winner index as the round robin pointer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "arb_params.svh"

module grant_select
  import arb_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  arb_mode_e            arb_mode,
  input  logic [`ARB_NREQ-1:0] cand_p0,
  input  logic [`ARB_NREQ-1:0] cand_p1,
  input  logic [`ARB_NREQ-1:0] cand_p2,
  input  logic [`ARB_NREQ-1:0] cand_p3,
  input  logic [`ARB_NREQ-1:0] cand_rr,
  input  logic [`ARB_NREQ-1:0] cand_rand,
  output logic [`ARB_NREQ-1:0] gnt,
  output logic [1:0]           rr_ptr
);

  // New decision every cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt <= '0;
    end else begin
      case (arb_mode)
        MODE_P0:   gnt <= cand_p0;
        MODE_P1:   gnt <= cand_p1;
        MODE_P2:   gnt <= cand_p2;
        MODE_P3:   gnt <= cand_p3;
        MODE_RR:   gnt <= cand_rr;
        MODE_RAND: gnt <= cand_rand;
        default:   gnt <= '0;  // Codes 6 and 7
      endcase
    end
  end

  // One-hot to index, zero grant maps to index 0
  assign rr_ptr = {gnt[3] | gnt[2], gnt[3] | gnt[1]};

endmodule

// File: hw/arbiter_top.sv
//////////////////////////////////////////////////////////////////////
// Four-requester arbiter
// Six schemes, grant registered one cycle after the requests
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "arb_params.svh"

module arbiter_top
  import arb_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`ARB_NREQ-1:0]   req,
  input  logic [`ARB_MODE_W-1:0] arb_mode,
  output logic [`ARB_NREQ-1:0]   gnt
);

  arb_mode_e            mode_sel;
  logic [`ARB_NREQ-1:0] cand_p0;
  logic [`ARB_NREQ-1:0] cand_p1;
  logic [`ARB_NREQ-1:0] cand_p2;
  logic [`ARB_NREQ-1:0] cand_p3;
  logic [`ARB_NREQ-1:0] cand_rr;
  logic [`ARB_NREQ-1:0] cand_rand;
  logic [1:0]           rr_ptr;    // Last winner index

  // Unused codes pass through and decode to no grant
  assign mode_sel = arb_mode_e'(arb_mode);

  static_grant static_grant_inst (
    .req     (req),
    .rr_ptr  (rr_ptr),
    .cand_p0 (cand_p0),
    .cand_p1 (cand_p1),
    .cand_p2 (cand_p2),
    .cand_p3 (cand_p3),
    .cand_rr (cand_rr)
  );

  random_grant random_grant_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .cand_rand (cand_rand)
  );

  grant_select grant_select_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .arb_mode  (mode_sel),
    .cand_p0   (cand_p0),
    .cand_p1   (cand_p1),
    .cand_p2   (cand_p2),
    .cand_p3   (cand_p3),
    .cand_rr   (cand_rr),
    .cand_rand (cand_rand),
    .gnt       (gnt),
    .rr_ptr    (rr_ptr)
  );

endmodule

// File: test/arbiter_props.sv
//////////////////////////////////////////////////////////////////////
// Arbiter grant properties
// Bound to the top level, checks grant shape and its causes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "arb_params.svh"

module arbiter_props
  import arb_pkg::*;
(
  input logic                   clk,
  input logic                   rst_n,
  input logic [`ARB_NREQ-1:0]   req,
  input logic [`ARB_MODE_W-1:0] arb_mode,
  input logic [`ARB_NREQ-1:0]   gnt
);

  property gnt_onehot0;
    @(posedge clk) disable iff (!rst_n) $onehot0(gnt);
  endproperty

  // Grant bits follow last cycle's requests
  property gnt_needs_req;
    @(posedge clk) disable iff (!rst_n) (gnt & ~$past(req)) == '0;
  endproperty

  property unused_mode_no_gnt;
    @(posedge clk) disable iff (!rst_n) ($past(arb_mode) > MODE_RAND) |-> (gnt == '0);
  endproperty

  a_gnt_onehot0: assert property (gnt_onehot0)
    else $error("gnt has more than one bit set: %b", gnt);
  a_gnt_needs_req: assert property (gnt_needs_req)
    else $error("grant %b given to a requester that was not requesting", gnt);
  a_unused_mode: assert property (unused_mode_no_gnt)
    else $error("unused mode code produced grant %b", gnt);

endmodule

bind arbiter_top arbiter_props arbiter_props_inst (
  .clk      (clk),
  .rst_n    (rst_n),
  .req      (req),
  .arb_mode (arb_mode),
  .gnt      (gnt)
);

// File: test/arbiter_tb.sv
//////////////////////////////////////////////////////////////////////
// Arbiter testbench
// Directed tests against a reference model of all six schemes,
// with one result line per test and a closing summary
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "arb_params.svh"

module arbiter_tb
  import arb_pkg::*;
;

  logic                   clk;
  logic                   rst_n;
  logic [`ARB_NREQ-1:0]   req;
  logic [`ARB_MODE_W-1:0] arb_mode;
  logic [`ARB_NREQ-1:0]   gnt;

  logic [2:0]           pn_model;   // {s3, s2, s1}
  logic [`ARB_NREQ-1:0] model_gnt;  // Model grant register
  integer               seed;
  int                   error_count;
  int                   check_count;
  int                   test_count;
  bit                   timed_out;

  // Head order of the generator from reset
  logic [1:0] pn_heads [0:6] = '{2'd0, 2'd1, 2'd3, 2'd3, 2'd2, 2'd1, 2'd2};

  arbiter_top arbiter_top_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .arb_mode (arb_mode),
    .gnt      (gnt)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Generator copy, stepped on every edge after reset
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pn_model <= `ARB_PN_INIT;
    end else begin
      pn_model <= {pn_model[1], pn_model[0], pn_model[0] ^ pn_model[2]};
    end
  end

  function automatic logic [1:0] grant_index(input logic [`ARB_NREQ-1:0] g);
    logic [1:0] idx;
    idx = 2'd0;  // Zero grant maps to 0
    for (int i = 0; i < `ARB_NREQ; i++) begin
      if (g[i]) idx = i[1:0];
    end
    return idx;
  endfunction

  // Head first, otherwise the lowest set bit
  function automatic logic [`ARB_NREQ-1:0] head_first_pick(
    input logic [`ARB_NREQ-1:0] r,
    input logic [1:0]           head
  );
    if (r[head]) return 4'b0001 << head;
    return r & (~r + 4'd1);
  endfunction

  // Next grant from the model state and the driven inputs
  function automatic logic [`ARB_NREQ-1:0] predict_grant(
    input logic [`ARB_NREQ-1:0]   r,
    input logic [`ARB_MODE_W-1:0] m
  );
    logic [`ARB_NREQ-1:0]   p;
    logic [2*`ARB_NREQ-1:0] dbl;
    logic [`ARB_NREQ-1:0]   rot;
    logic [`ARB_NREQ-1:0]   sel;
    int                     sh;
    p = '0;
    case (m)
      3'd0, 3'd1, 3'd2, 3'd3: p = head_first_pick(r, m[1:0]);
      3'd4: begin
        // Rotate so the requester after the pointer sits at bit 0
        sh  = grant_index(model_gnt) + 1;
        dbl = {r, r};
        rot = dbl[sh +: 4];
        sel = pick_from_head(rot, 2'd0);
        for (int j = 0; j < `ARB_NREQ; j++) begin
          if (sel[j]) p[(j + sh) % 4] = 1'b1;
        end
      end
      3'd5:    p = head_first_pick(r, pn_model[2:1]);
      default: p = '0;
    endcase
    return p;
  endfunction

  task automatic check_value(
    input logic [`ARB_NREQ-1:0] actual,
    input logic [`ARB_NREQ-1:0] expected,
    input string                msg
  );
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("MISMATCH at %0t: %s, got %b expected %b", $time, msg, actual, expected);
    end
  endtask

  // Drive one cycle and compare the grant one edge later
  task automatic drive_and_check(
    input logic [`ARB_NREQ-1:0]   r,
    input logic [`ARB_MODE_W-1:0] m,
    input string                  what
  );
    logic [`ARB_NREQ-1:0] expected;
    req      = r;
    arb_mode = m;
    expected = predict_grant(r, m);
    @(posedge clk);
    #1;
    model_gnt = expected;
    check_value(gnt, expected, what);
  endtask

  task automatic apply_reset();
    rst_n     = 1'b0;
    req       = '0;
    arb_mode  = '0;
    model_gnt = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  task automatic wait_for_grant(
    input logic [`ARB_NREQ-1:0]   target,
    input logic [`ARB_NREQ-1:0]   r,
    input logic [`ARB_MODE_W-1:0] m,
    input int                     limit
  );
    int cycles;
    cycles = 0;
    while ((gnt != target) && (cycles < limit)) begin
      drive_and_check(r, m, "wait for grant");
      cycles++;
    end
    if (gnt != target) begin
      $display("Timeout: grant %b did not appear within %0d cycles", target, limit);
      timed_out = 1'b1;
    end
  endtask

  task automatic report_test(input string name, input int start_err);
    test_count++;
    if (error_count == start_err) $display("%-24s ok", name);
    else $display("%-24s %0d errors", name, error_count - start_err);
  endtask

  task automatic idle_after_reset();
    int start_err;
    start_err = error_count;
    apply_reset();
    check_value(gnt, 4'b0000, "gnt after reset");
    for (int m = 0; m < 8; m++) begin
      drive_and_check(4'b0000, m[2:0], "idle request");
    end
    report_test("idle after reset", start_err);
  endtask

  task automatic fixed_priority_sweep();
    int start_err;
    start_err = error_count;
    for (int h = 0; h < 4; h++) begin
      for (int pat = 0; pat < 16; pat++) begin
        drive_and_check(pat[3:0], h[2:0], "fixed priority");
      end
    end
    report_test("fixed priority", start_err);
  endtask

  task automatic round_robin_rotation();
    int                   start_err;
    logic [`ARB_NREQ-1:0] exp_rot;
    logic [31:0]          rnd;
    start_err = error_count;
    wait_for_grant(4'b0001, 4'b1111, MODE_RR, 8);
    if (!timed_out) begin
      exp_rot = 4'b0001;
      for (int i = 0; i < 8; i++) begin
        exp_rot = {exp_rot[2:0], exp_rot[3]};  // 1, 2, 3, 0
        drive_and_check(4'b1111, MODE_RR, "rr all requesting");
        check_value(gnt, exp_rot, "rr rotation order");
      end
      for (int i = 0; i < 40; i++) begin
        rnd = $random(seed);
        drive_and_check(rnd[3:0] & rnd[7:4], MODE_RR, "rr sparse");  // About one bit in four
      end
    end
    report_test("round robin", start_err);
  endtask

  task automatic random_head_sequence();
    int          start_err;
    logic [31:0] rnd;
    start_err = error_count;
    apply_reset();
    for (int i = 0; i < 14; i++) begin
      drive_and_check(4'b1111, MODE_RAND, "random all requesting");
      check_value(gnt, 4'b0001 << pn_heads[i % 7], "random head sequence");
    end
    for (int i = 0; i < 40; i++) begin
      rnd = $random(seed);
      drive_and_check(rnd[3:0], MODE_RAND, "random patterns");
    end
    report_test("random mode", start_err);
  endtask

  task automatic mode_switching();
    int                     start_err;
    logic [31:0]            rnd;
    logic [`ARB_MODE_W-1:0] m;
    start_err = error_count;
    drive_and_check(4'b1111, 3'd6, "unused code 6");
    check_value(gnt, 4'b0000, "code 6 grant");
    drive_and_check(4'b1111, 3'd7, "unused code 7");
    check_value(gnt, 4'b0000, "code 7 grant");
    for (int i = 0; i < 64; i++) begin
      rnd = $random(seed);
      m   = rnd[6:4];
      drive_and_check(rnd[3:0], m, "mode switching");
      if (m >= 3'd6) check_value(gnt, 4'b0000, "unused mode grant");
    end
    report_test("mode switching", start_err);
  endtask

  initial begin
    rst_n       = 1'b0;
    req         = '0;
    arb_mode    = '0;
    model_gnt   = '0;
    seed        = 32'h891ae24d;
    error_count = 0;
    check_count = 0;
    test_count  = 0;
    timed_out   = 1'b0;

    idle_after_reset();
    fixed_priority_sweep();
    round_robin_rotation();
    if (!timed_out) random_head_sequence();
    if (!timed_out) mode_switching();

    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if ((error_count == 0) && !timed_out) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+hw
hw/arb_pkg.sv
hw/pn_seq_gen.sv
hw/static_grant.sv
hw/random_grant.sv
hw/grant_select.sv
hw/arbiter_top.sv
test/arbiter_props.sv
test/arbiter_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the arbiter testbench with Verilator.
# Pass or fail is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=arbiter_sim
LOG_FILE=sim.log

verilator --binary --timing --assert \
  -f tb.f \
  --top-module arbiter_tb \
  -Mdir "$BUILD_DIR" \
  -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG_FILE"; then
  echo "Result: pass"
  exit 0
else
  echo "Result: fail"
  exit 1
fi
